/* Makefile */
.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run and check the log"
	@echo "make clean  remove build output and log"

test:
	verilator --binary --timing --assert -Wno-fatal -f rv32i_cpu.f --top-module tb_rv32i_cpu -Mdir obj_dir -o sim
	./obj_dir/sim | tee sim.log
	grep -q "No errors" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/rv32i_cpu_chk.sv */
// ========================================
// Control assertions bound to the core
// ========================================
`timescale 1ns/1ps

module rv32i_cpu_chk (
  input logic        clk,
  input logic        reset,
  input logic        mem_write,
  input logic        stall,
  input logic [31:0] pc
);

  int fail_count = 0;

  a_no_write_in_reset: assert property (@(posedge clk) reset |-> !mem_write)
    else
    begin
      fail_count++;
      $error("Store strobe high during reset");
    end

  // Load-use stall holds fetch
  a_pc_held: assert property (@(posedge clk) disable iff (reset) stall |=> pc == $past(pc))
    else
    begin
      fail_count++;
      $error("PC moved during a stall");
    end

  a_pc_aligned: assert property (@(posedge clk) pc[1:0] == 2'b00)
    else
    begin
      fail_count++;
      $error("PC not word aligned");
    end

endmodule

bind rv32i_cpu rv32i_cpu_chk u_chk (
  .clk       (clk),
  .reset     (reset),
  .mem_write (mem_write),
  .stall     (u_datapath.stall),
  .pc        (pc)
);

/* bench/tb_rv32i_cpu.sv */
// ========================================
// Testbench for the pipelined RV32I core
// and its store result checker
// ========================================
`timescale 1ns/1ps
`include "rv32i_consts.svh"

module rv32i_result_check (
  input logic        clk,
  input logic        reset,
  input logic        mem_write,
  input logic [31:0] mem_addr,
  input logic [31:0] mem_wdata
);
  localparam logic [31:0] END_ADDR = 32'h100;

  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  string       row_name;
  int          errors = 0;
  logic        end_seen = 1'b0;

  task automatic start_row(input string name);
    row_name = name;
    end_seen = 1'b0;
    exp_addr.delete();
    exp_data.delete();
  endtask

  task automatic push_store(input logic [31:0] addr, input logic [31:0] data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  task automatic finish_row();
    if (exp_addr.size() != 0)
    begin
      $display("Row %s ended with %0d expected stores missing", row_name, exp_addr.size());
      errors++;
    end
  endtask

  always @(posedge clk)
  begin
    if (mem_write && reset)
    begin
      $display("Row %s issued a store while reset was high", row_name);
      errors++;
    end
    else if (mem_write)
    begin
      if (exp_addr.size() == 0)
      begin
        $display("Row %s issued an extra store to %h", row_name, mem_addr);
        errors++;
      end
      else
      begin
        if (mem_addr !== exp_addr[0])
        begin
          $display("Mismatch %s address: expected %h actual %h", row_name, exp_addr[0], mem_addr);
          errors++;
        end
        if (mem_wdata !== exp_data[0])
        begin
          $display("Mismatch %s data: expected %h actual %h", row_name, exp_data[0], mem_wdata);
          errors++;
        end
        void'(exp_addr.pop_front());
        void'(exp_data.pop_front());
      end
      if (mem_addr == END_ADDR)
        end_seen = 1'b1;
    end
  end

endmodule

module tb_rv32i_cpu;
  import rv32i_pkg::*;

  localparam int ROWS = 8;
  localparam int ROW_CYCLES = 200;
  localparam word_t BAD = 32'hFFFF_FBAD; // addi of 0xBAD sign-extends

  logic  clk = 1'b0;
  logic  reset = 1'b1;
  word_t pc, inst, mem_addr, mem_wdata, mem_rdata;
  logic  mem_write;
  word_t imem [0:63];
  word_t dmem [0:127];
  string names [ROWS];
  word_t av [ROWS];
  word_t bv [ROWS];

  always #2 clk = ~clk;

  assign inst      = imem[pc[7:2]];
  assign mem_rdata = dmem[mem_addr[8:2]]; // Combinational read

  always @(posedge clk)
  begin
    if (mem_write)
      dmem[mem_addr[8:2]] <= mem_wdata;
  end

  rv32i_cpu UUT (
    .clk       (clk),
    .reset     (reset),
    .pc        (pc),
    .inst      (inst),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata)
  );

  rv32i_result_check chk (
    .clk       (clk),
    .reset     (reset),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata)
  );

  function automatic word_t r_type(input logic [6:0] f7, input int rs2, input int rs1,
                                   input logic [2:0] f3, input int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), `OPC_R};
  endfunction

  function automatic word_t i_type(input int imm, input int rs1, input logic [2:0] f3,
                                   input int rd, input logic [6:0] op);
    return {12'(imm), 5'(rs1), f3, 5'(rd), op};
  endfunction

  function automatic word_t s_type(input int imm, input int rs2);
    logic [11:0] i;
    i = 12'(imm);
    return {i[11:5], 5'(rs2), 5'd0, 3'b010, i[4:0], `OPC_STORE};
  endfunction

  function automatic word_t b_type(input int off, input int rs2, input int rs1,
                                   input logic [2:0] f3);
    logic [12:0] o;
    o = 13'(off);
    return {o[12], o[10:5], 5'(rs2), 5'(rs1), f3, o[4:1], o[11], `OPC_BRANCH};
  endfunction

  function automatic word_t j_type(input int off, input int rd);
    logic [20:0] o;
    o = 21'(off);
    return {o[20], o[10:1], o[11], o[19:12], 5'(rd), `OPC_JAL};
  endfunction

  task automatic load_program();
    for (int i = 0; i < 64; i++)
      imem[i] = i_type(i, 0, 3'b000, 0, `OPC_I_ARITH); // Nop tagged with its index
    imem[0]  = i_type(0, 0, 3'b010, 1, `OPC_LOAD);
    imem[1]  = i_type(4, 0, 3'b010, 2, `OPC_LOAD);
    imem[2]  = r_type(7'h00, 2, 1, 3'b000, 3); // Uses x2 straight after its load
    imem[3]  = s_type(16, 3);
    imem[4]  = r_type(7'h20, 2, 1, 3'b000, 4);
    imem[5]  = s_type(20, 4);
    imem[6]  = r_type(7'h00, 2, 1, 3'b111, 5);
    imem[7]  = s_type(24, 5);
    imem[8]  = r_type(7'h00, 2, 1, 3'b110, 6);
    imem[9]  = s_type(28, 6);
    imem[10] = r_type(7'h00, 2, 1, 3'b100, 7);
    imem[11] = s_type(32, 7);
    imem[12] = r_type(7'h00, 2, 1, 3'b001, 8);
    imem[13] = s_type(36, 8);
    imem[14] = r_type(7'h00, 2, 1, 3'b101, 9);
    imem[15] = s_type(40, 9);
    // Signed and unsigned branch blocks of the same shape
    imem[16] = b_type(20, 2, 1, `F3_BLT);
    imem[17] = i_type(12'hBAD, 0, 3'b000, 10, `OPC_I_ARITH);
    imem[18] = s_type(44, 10);
    imem[19] = s_type(48, 0);
    imem[20] = j_type(12, 0);
    imem[21] = i_type(1, 0, 3'b000, 11, `OPC_I_ARITH);
    imem[22] = s_type(48, 11);
    imem[23] = b_type(20, 2, 1, `F3_BLTU);
    imem[24] = i_type(12'hBAD, 0, 3'b000, 10, `OPC_I_ARITH);
    imem[25] = s_type(52, 10);
    imem[26] = s_type(56, 0);
    imem[27] = j_type(12, 0);
    imem[28] = i_type(1, 0, 3'b000, 11, `OPC_I_ARITH);
    imem[29] = s_type(56, 11);
    imem[30] = j_type(8, 12);
    imem[31] = j_type(12, 0); // Return point of the jalr
    imem[32] = s_type(60, 12);
    imem[33] = i_type(0, 12, 3'b000, 0, `OPC_JALR);
    imem[34] = {20'h12345, 5'd13, `OPC_LUI};
    imem[35] = s_type(64, 13);
    imem[36] = {20'h00ABC, 5'd14, `OPC_AUIPC};
    imem[37] = s_type(68, 14);
    imem[38] = i_type(1, 0, 3'b000, 15, `OPC_I_ARITH);
    imem[39] = s_type(256, 15); // End marker
    imem[40] = j_type(0, 0);
  endtask

  task automatic expect_row(input word_t a, input word_t b);
    chk.push_store(16, a + b);
    chk.push_store(20, a - b);
    chk.push_store(24, a & b);
    chk.push_store(28, a | b);
    chk.push_store(32, a ^ b);
    chk.push_store(36, a << b[4:0]);
    chk.push_store(40, a >> b[4:0]);
    if ($signed(a) < $signed(b))
      chk.push_store(48, 1);
    else
    begin
      chk.push_store(44, BAD);
      chk.push_store(48, 0);
    end
    if (a < b)
      chk.push_store(56, 1);
    else
    begin
      chk.push_store(52, BAD);
      chk.push_store(56, 0);
    end
    chk.push_store(60, 32'd124);
    chk.push_store(64, 32'h1234_5000);
    chk.push_store(68, 32'h0000_0090 + 32'h00AB_C000);
    chk.push_store(256, 1);
  endtask

  initial
  begin
    #(ROWS * (ROW_CYCLES + 24) * 4);
    $display("Timeout: the end marker store did not arrive in time");
    $display("Errors found");
    $finish;
  end

  initial
  begin
    void'($urandom(60));
    names = '{"small", "neg_a", "neg_b", "equal", "zero_a", "min_int", "rand_0", "rand_1"};
    av = '{32'd5, -32'sd7, 32'd9, 32'd100, 32'd0, 32'h8000_0000, 32'd0, 32'd0};
    bv = '{32'd3, 32'd4, -32'sd2, 32'd100, 32'h1234, 32'd1, 32'd0, 32'd0};
    av[6] = $urandom();
    bv[6] = $urandom();
    av[7] = $urandom();
    bv[7] = $urandom();
    for (int i = 0; i < 128; i++)
      dmem[i] = 32'hD000_0000 | i;
    load_program();
    for (int r = 0; r < ROWS; r++)
    begin
      @(negedge clk);
      reset = 1'b1;
      dmem[0] = av[r];
      dmem[1] = bv[r];
      chk.start_row(names[r]);
      expect_row(av[r], bv[r]);
      repeat (16) @(negedge clk);
      reset = 1'b0;
      while (!chk.end_seen)
        @(posedge clk);
      repeat (4) @(posedge clk);
      chk.finish_row();
    end
    $display("Store errors %0d, assertion failures %0d", chk.errors, UUT.u_chk.fail_count);
    if (chk.errors == 0 && UUT.u_chk.fail_count == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

/* common/rv32i_consts.svh */
// ========================================
// Width, opcode, funct3, ALU control and
// forwarding select macros
// ========================================
`ifndef RV32I_CONSTS_SVH
`define RV32I_CONSTS_SVH

`define XLEN       32
`define REG_ADDR_W 5

// Major opcodes in inst[6:0]
`define OPC_R       7'b0110011
`define OPC_I_ARITH 7'b0010011
`define OPC_LOAD    7'b0000011
`define OPC_JALR    7'b1100111
`define OPC_STORE   7'b0100011
`define OPC_BRANCH  7'b1100011
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_JAL     7'b1101111

`define ALU_ADD 5'b00000
`define ALU_SUB 5'b10000 // Also used for branch compares
`define ALU_AND 5'b00001
`define ALU_OR  5'b00010
`define ALU_XOR 5'b00011
`define ALU_SLL 5'b00100
`define ALU_SRL 5'b00101

`define F3_BEQ  3'b000
`define F3_BNE  3'b001
`define F3_BLT  3'b100
`define F3_BGE  3'b101
`define F3_BLTU 3'b110
`define F3_BGEU 3'b111

// Operand source in execute
`define FWD_REG 2'b00
`define FWD_WB  2'b01
`define FWD_MEM 2'b10

`endif

/* common/rv32i_pkg.sv */
// ========================================
// Vector types shared across the core
// ========================================
package rv32i_pkg;
  `include "rv32i_consts.svh"

  typedef logic [`XLEN-1:0]       word_t;     // Data, address or instruction
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [4:0]             alu_ctrl_t;
  typedef logic [2:0]             funct3_t;

endpackage

/* datapath/alu.sv */
// ========================================
// ALU with N, Z, C and V flags
// ========================================
`timescale 1ns/1ps
`include "rv32i_consts.svh"

module alu (
  input  rv32i_pkg::word_t     a,
  input  rv32i_pkg::word_t     b,
  input  rv32i_pkg::alu_ctrl_t alu_ctrl,
  output rv32i_pkg::word_t     result,
  output logic                 n,
  output logic                 z,
  output logic                 c,
  output logic                 v
);
  import rv32i_pkg::*;

  logic  sub;
  word_t b_op; // b inverted when subtracting
  word_t sum;

  assign sub      = (alu_ctrl == `ALU_SUB);
  assign b_op     = sub ? ~b : b;
  assign {c, sum} = {1'b0, a} + {1'b0, b_op} + {{`XLEN{1'b0}}, sub};

  // Signed overflow of the adder
  assign v = (a[`XLEN-1] == b_op[`XLEN-1]) && (sum[`XLEN-1] != a[`XLEN-1]);

  always_comb
  begin
    case (alu_ctrl)
      `ALU_AND: result = a & b;
      `ALU_OR:  result = a | b;
      `ALU_XOR: result = a ^ b;
      `ALU_SLL: result = a << b[4:0];
      `ALU_SRL: result = a >> b[4:0];
      default:  result = sum; // Add and subtract
    endcase
  end

  assign n = result[`XLEN-1];
  assign z = (result == '0);

endmodule

/* datapath/hazard_unit.sv */
// ========================================
// Forwarding selects, decode bypass and
// load-use stall detection
// ========================================
`timescale 1ns/1ps
`include "rv32i_consts.svh"

module hazard_unit (
  input  rv32i_pkg::reg_addr_t id_rs1,
  input  rv32i_pkg::reg_addr_t id_rs2,
  input  rv32i_pkg::reg_addr_t ex_rs1,
  input  rv32i_pkg::reg_addr_t ex_rs2,
  input  rv32i_pkg::reg_addr_t ex_rd,
  input  rv32i_pkg::reg_addr_t mem_rd,
  input  rv32i_pkg::reg_addr_t wb_rd,
  input  logic                 ex_memtoreg,
  input  logic                 ex_alusrc,
  input  logic                 ex_mem_write_en,
  input  logic                 mem_regwrite,
  input  logic                 wb_regwrite,
  output logic [1:0]           fwd_a_sel,
  output logic [1:0]           fwd_b_sel,
  output logic                 id_bypass_rs1,
  output logic                 id_bypass_rs2,
  output logic [1:0]           store_fwd_sel,
  output logic                 stall
);

  logic       mem_valid;  // Memory stage writes a real register
  logic       wb_valid;
  logic       load_valid;
  logic [1:0] rs2_sel;

  assign mem_valid  = mem_regwrite && (mem_rd != '0);
  assign wb_valid   = wb_regwrite && (wb_rd != '0);
  assign load_valid = ex_memtoreg && (ex_rd != '0);

  // Younger result in the memory stage wins
  assign fwd_a_sel = (mem_valid && (mem_rd == ex_rs1)) ? `FWD_MEM :
                     (wb_valid && (wb_rd == ex_rs1))   ? `FWD_WB  : `FWD_REG;
  assign rs2_sel   = (mem_valid && (mem_rd == ex_rs2)) ? `FWD_MEM :
                     (wb_valid && (wb_rd == ex_rs2))   ? `FWD_WB  : `FWD_REG;

  assign fwd_b_sel     = ex_alusrc ? `FWD_REG : rs2_sel; // Immediate takes operand b
  assign store_fwd_sel = ex_mem_write_en ? rs2_sel : `FWD_REG;

  assign id_bypass_rs1 = wb_valid && (wb_rd == id_rs1);
  assign id_bypass_rs2 = wb_valid && (wb_rd == id_rs2);

  assign stall = load_valid && ((ex_rd == id_rs1) || (ex_rd == id_rs2));

endmodule

/* datapath/pipeline_datapath.sv */
// ========================================
// PC, pipeline registers, operand muxes,
// branch resolution and write-back select
// ========================================
`timescale 1ns/1ps
`include "rv32i_consts.svh"

module pipeline_datapath (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 auipc,
  input  logic                 lui,
  input  logic                 alusrc,
  input  logic                 memtoreg,
  input  logic                 mem_write_en,
  input  logic                 branch,
  input  logic                 jal,
  input  logic                 jalr,
  input  logic                 regwrite,
  input  rv32i_pkg::alu_ctrl_t alu_ctrl,
  output rv32i_pkg::word_t     id_inst,
  output rv32i_pkg::word_t     pc,
  input  rv32i_pkg::word_t     inst,
  output logic                 mem_write,
  output rv32i_pkg::word_t     mem_addr,
  output rv32i_pkg::word_t     mem_wdata,
  input  rv32i_pkg::word_t     mem_rdata
);
  import rv32i_pkg::*;

  word_t      id_pc, rf_rs1, rf_rs2, id_a, id_b, id_alu_imm, id_offset;
  word_t      imm_i, imm_s, imm_b, imm_j, imm_u;
  reg_addr_t  id_rs1, id_rs2;
  logic [8:0] id_ctrl, ex_ctrl;
  word_t      ex_pc, ex_a, ex_b, ex_imm, ex_offset;
  word_t      ex_rs1_fwd, ex_rs2_fwd, alu_a, alu_b, alu_result, target;
  funct3_t    ex_funct3;
  reg_addr_t  ex_rs1, ex_rs2, ex_rd, ma_rd, wb_rd;
  alu_ctrl_t  ex_alu_ctrl;
  logic       ex_auipc, ex_lui, ex_alusrc, ex_memtoreg, ex_mem_write_en;
  logic       ex_branch, ex_jal, ex_jalr, ex_regwrite;
  logic       n, z, c, v, cond, redirect;
  word_t      ma_pc, wb_pc, wb_alu, wb_rdata, wb_data;
  logic       ma_memtoreg, ma_regwrite, ma_jump, wb_memtoreg, wb_regwrite, wb_jump;
  logic [1:0] fwd_a_sel, fwd_b_sel, store_fwd_sel;
  logic       id_bypass_rs1, id_bypass_rs2, stall;

  function automatic word_t fwd_pick(input logic [1:0] sel, input word_t reg_val,
                                     input word_t mem_val, input word_t wb_val);
    case (sel)
      `FWD_MEM: fwd_pick = mem_val;
      `FWD_WB:  fwd_pick = wb_val;
      default:  fwd_pick = reg_val;
    endcase
  endfunction

  // Redirect takes priority over a stall in fetch
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      pc      <= '0;
      id_inst <= '0; // Opcode 0 decodes as a no-op
    end
    else if (redirect)
    begin
      pc      <= target;
      id_inst <= '0;
    end
    else if (!stall)
    begin
      pc      <= pc + word_t'(4);
      id_inst <= inst;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!stall)
      id_pc <= pc;
  end

  // Decode
  assign id_rs1 = id_inst[19:15];
  assign id_rs2 = id_inst[24:20];
  assign imm_i  = {{20{id_inst[31]}}, id_inst[31:20]};
  assign imm_s  = {{20{id_inst[31]}}, id_inst[31:25], id_inst[11:7]};
  assign imm_b  = {{20{id_inst[31]}}, id_inst[7], id_inst[30:25], id_inst[11:8], 1'b0};
  assign imm_j  = {{12{id_inst[31]}}, id_inst[19:12], id_inst[20], id_inst[30:21], 1'b0};
  assign imm_u  = {id_inst[31:12], 12'b0};

  assign id_alu_imm = (auipc || lui) ? imm_u : (mem_write_en ? imm_s : imm_i);
  assign id_offset  = jal ? imm_j : imm_b;
  assign id_a       = id_bypass_rs1 ? wb_data : rf_rs1; // Same-cycle write-back
  assign id_b       = id_bypass_rs2 ? wb_data : rf_rs2;
  assign id_ctrl    = {auipc, lui, alusrc, memtoreg, mem_write_en, branch, jal, jalr, regwrite};

  assign {ex_auipc, ex_lui, ex_alusrc, ex_memtoreg, ex_mem_write_en,
          ex_branch, ex_jal, ex_jalr, ex_regwrite} = ex_ctrl;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      ex_ctrl <= '0;
    else
      ex_ctrl <= (stall || redirect) ? '0 : id_ctrl; // Bubble into execute
  end

  always_ff @(posedge clk)
  begin
    ex_pc       <= id_pc;
    ex_funct3   <= id_inst[14:12];
    ex_rs1      <= id_rs1;
    ex_rs2      <= id_rs2;
    ex_rd       <= id_inst[11:7];
    ex_a        <= id_a;
    ex_b        <= id_b;
    ex_imm      <= id_alu_imm;
    ex_offset   <= id_offset;
    ex_alu_ctrl <= alu_ctrl;
  end

  // Execute
  assign ex_rs1_fwd = fwd_pick(fwd_a_sel, ex_a, mem_addr, wb_data);
  assign ex_rs2_fwd = fwd_pick(fwd_b_sel, ex_b, mem_addr, wb_data);
  assign alu_a      = ex_auipc ? ex_pc : (ex_lui ? '0 : ex_rs1_fwd);
  assign alu_b      = ex_alusrc ? ex_imm : ex_rs2_fwd;

  always_comb
  begin
    case (ex_funct3)
      `F3_BEQ:  cond = z;
      `F3_BNE:  cond = !z;
      `F3_BLT:  cond = (n != v);
      `F3_BGE:  cond = (n == v);
      `F3_BLTU: cond = !c; // Borrow out of a - b
      `F3_BGEU: cond = c;
      default:  cond = 1'b0;
    endcase
  end

  assign redirect = (ex_branch && cond) || ex_jal || ex_jalr;
  assign target   = ex_jalr ? {alu_result[31:1], 1'b0} : ex_pc + ex_offset;

  // Memory and write-back control
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      mem_write   <= 1'b0;
      ma_memtoreg <= 1'b0;
      ma_regwrite <= 1'b0;
      ma_jump     <= 1'b0;
      wb_memtoreg <= 1'b0;
      wb_regwrite <= 1'b0;
      wb_jump     <= 1'b0;
    end
    else
    begin
      mem_write   <= ex_mem_write_en;
      ma_memtoreg <= ex_memtoreg;
      ma_regwrite <= ex_regwrite;
      ma_jump     <= ex_jal || ex_jalr;
      wb_memtoreg <= ma_memtoreg;
      wb_regwrite <= ma_regwrite;
      wb_jump     <= ma_jump;
    end
  end

  always_ff @(posedge clk)
  begin
    ma_pc     <= ex_pc;
    ma_rd     <= ex_rd;
    mem_addr  <= alu_result;
    mem_wdata <= fwd_pick(store_fwd_sel, ex_b, mem_addr, wb_data);
    wb_pc     <= ma_pc;
    wb_rd     <= ma_rd;
    wb_alu    <= mem_addr;
    wb_rdata  <= mem_rdata;
  end

  always_comb
  begin
    if (wb_jump)
      wb_data = wb_pc + word_t'(4); // Link address
    else if (wb_memtoreg)
      wb_data = wb_rdata;
    else
      wb_data = wb_alu;
  end

  regfile u_regfile (
    .clk      (clk),
    .we       (wb_regwrite),
    .rs1      (id_rs1),
    .rs2      (id_rs2),
    .rd       (wb_rd),
    .rd_data  (wb_data),
    .rs1_data (rf_rs1),
    .rs2_data (rf_rs2)
  );

  alu u_alu (
    .a        (alu_a),
    .b        (alu_b),
    .alu_ctrl (ex_alu_ctrl),
    .result   (alu_result),
    .n        (n),
    .z        (z),
    .c        (c),
    .v        (v)
  );

  hazard_unit u_hazard (
    .id_rs1          (id_rs1),
    .id_rs2          (id_rs2),
    .ex_rs1          (ex_rs1),
    .ex_rs2          (ex_rs2),
    .ex_rd           (ex_rd),
    .mem_rd          (ma_rd),
    .wb_rd           (wb_rd),
    .ex_memtoreg     (ex_memtoreg),
    .ex_alusrc       (ex_alusrc),
    .ex_mem_write_en (ex_mem_write_en),
    .mem_regwrite    (ma_regwrite),
    .wb_regwrite     (wb_regwrite),
    .fwd_a_sel       (fwd_a_sel),
    .fwd_b_sel       (fwd_b_sel),
    .id_bypass_rs1   (id_bypass_rs1),
    .id_bypass_rs2   (id_bypass_rs2),
    .store_fwd_sel   (store_fwd_sel),
    .stall           (stall)
  );

endmodule

/* datapath/regfile.sv */
// ========================================
// 32-entry register file, x0 reads zero
// ========================================
`timescale 1ns/1ps

module regfile (
  input  logic                 clk,
  input  logic                 we,
  input  rv32i_pkg::reg_addr_t rs1,
  input  rv32i_pkg::reg_addr_t rs2,
  input  rv32i_pkg::reg_addr_t rd,
  input  rv32i_pkg::word_t     rd_data,
  output rv32i_pkg::word_t     rs1_data,
  output rv32i_pkg::word_t     rs2_data
);
  import rv32i_pkg::*;

  word_t regs [1:31]; // No storage behind x0

  always_ff @(posedge clk)
  begin
    if (we && (rd != '0))
      regs[rd] <= rd_data;
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* rv32i_cpu.f */
+incdir+common
common/rv32i_pkg.sv
source/inst_decoder.sv
datapath/regfile.sv
datapath/alu.sv
datapath/hazard_unit.sv
datapath/pipeline_datapath.sv
source/rv32i_cpu.sv
bench/rv32i_cpu_chk.sv
bench/tb_rv32i_cpu.sv

/* source/inst_decoder.sv */
// ========================================
// Main and ALU decode of the IF/ID word
// ========================================
`timescale 1ns/1ps
`include "rv32i_consts.svh"

module inst_decoder (
  input  rv32i_pkg::word_t     inst,
  output logic                 auipc,
  output logic                 lui,
  output logic                 alusrc,
  output logic                 memtoreg,
  output logic                 mem_write_en,
  output logic                 branch,
  output logic                 jal,
  output logic                 jalr,
  output logic                 regwrite,
  output rv32i_pkg::alu_ctrl_t alu_ctrl
);
  import rv32i_pkg::*;

  logic [6:0] opcode;
  logic [6:0] funct7;
  funct3_t    funct3;
  logic [8:0] ctrl;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  assign {auipc, lui, regwrite, alusrc, memtoreg, mem_write_en, branch, jal, jalr} = ctrl;

  always_comb
  begin
    case (opcode)
      `OPC_R:       ctrl = 9'b001_000_000;
      `OPC_I_ARITH: ctrl = 9'b001_100_000;
      `OPC_LOAD:    ctrl = 9'b001_110_000;
      `OPC_JALR:    ctrl = 9'b001_100_001;
      `OPC_STORE:   ctrl = 9'b000_101_000;
      `OPC_BRANCH:  ctrl = 9'b000_000_100;
      `OPC_LUI:     ctrl = 9'b011_100_000;
      `OPC_AUIPC:   ctrl = 9'b101_100_000;
      `OPC_JAL:     ctrl = 9'b001_100_010;
      default:      ctrl = 9'b000_000_000; // Unknown opcode is a no-op
    endcase
  end

  // ALU decode defaults to add
  always_comb
  begin
    case (opcode)
      `OPC_R:
        case ({funct7, funct3})
          10'b0100000_000: alu_ctrl = `ALU_SUB;
          10'b0000000_111: alu_ctrl = `ALU_AND;
          10'b0000000_110: alu_ctrl = `ALU_OR;
          10'b0000000_100: alu_ctrl = `ALU_XOR;
          10'b0000000_001: alu_ctrl = `ALU_SLL;
          10'b0000000_101: alu_ctrl = `ALU_SRL;
          default:         alu_ctrl = `ALU_ADD;
        endcase
      `OPC_I_ARITH:
        case (funct3)
          3'b111:  alu_ctrl = `ALU_AND;
          3'b110:  alu_ctrl = `ALU_OR;
          3'b100:  alu_ctrl = `ALU_XOR;
          3'b001:  alu_ctrl = `ALU_SLL;
          3'b101:  alu_ctrl = `ALU_SRL;
          default: alu_ctrl = `ALU_ADD;
        endcase
      `OPC_BRANCH: alu_ctrl = `ALU_SUB; // Compare via flags
      default:     alu_ctrl = `ALU_ADD;
    endcase
  end

endmodule

/* source/rv32i_cpu.sv */
// ========================================
// Pipelined RV32I core top level
// ========================================
`timescale 1ns/1ps

module rv32i_cpu (
  input  logic             clk,
  input  logic             reset,
  output rv32i_pkg::word_t pc,
  input  rv32i_pkg::word_t inst,
  output logic             mem_write,
  output rv32i_pkg::word_t mem_addr,
  output rv32i_pkg::word_t mem_wdata,
  input  rv32i_pkg::word_t mem_rdata
);
  import rv32i_pkg::*;

  word_t     id_inst;  // IF/ID instruction
  alu_ctrl_t alu_ctrl;
  logic      auipc, lui, alusrc, memtoreg;
  logic      mem_write_en, branch, jal, jalr, regwrite;

  inst_decoder u_decoder (
    .inst         (id_inst),
    .auipc        (auipc),
    .lui          (lui),
    .alusrc       (alusrc),
    .memtoreg     (memtoreg),
    .mem_write_en (mem_write_en),
    .branch       (branch),
    .jal          (jal),
    .jalr         (jalr),
    .regwrite     (regwrite),
    .alu_ctrl     (alu_ctrl)
  );

  pipeline_datapath u_datapath (
    .clk          (clk),
    .reset        (reset),
    .auipc        (auipc),
    .lui          (lui),
    .alusrc       (alusrc),
    .memtoreg     (memtoreg),
    .mem_write_en (mem_write_en),
    .branch       (branch),
    .jal          (jal),
    .jalr         (jalr),
    .regwrite     (regwrite),
    .alu_ctrl     (alu_ctrl),
    .id_inst      (id_inst),
    .pc           (pc),
    .inst         (inst),
    .mem_write    (mem_write),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mem_rdata    (mem_rdata)
  );

endmodule
